/* design/ula_video_pkg.sv */
package ula_video_pkg;

	// visible screen size
	localparam int unsigned H_AREA = 256;
	localparam int unsigned V_AREA = 192;

	// one frame format, in pixel columns and lines
	// the right border is stored without the screen delay
	typedef struct packed {
		logic [9:0] rborder;
		logic [9:0] blank1;
		logic [9:0] hsync_len;
		logic [9:0] blank2;
		logic [9:0] htotal;
		logic [9:0] bborder;
		logic [9:0] vsync_len;
		logic [9:0] vtotal;
		logic [9:0] int_line;
		logic [9:0] int_start;
		logic [9:0] int_end;
	} frame_fmt_t;

	localparam frame_fmt_t FMT_128 = '{
		rborder: 10'd48, blank1: 10'd28, hsync_len: 10'd33, blank2: 10'd43,
		htotal: 10'd456, bborder: 10'd56, vsync_len: 10'd8, vtotal: 10'd311,
		int_line: 10'd248, int_start: 10'd0, int_end: 10'd64
	};

	localparam frame_fmt_t FMT_PENT = '{
		rborder: 10'd56, blank1: 10'd8, hsync_len: 10'd33, blank2: 10'd23,
		htotal: 10'd448, bborder: 10'd56, vsync_len: 10'd8, vtotal: 10'd320,
		int_line: 10'd239, int_start: 10'd318, int_end: 10'd384
	};

	typedef logic [8:0] hcount_t;
	typedef logic [9:0] hphase_t;
	typedef logic [8:0] vcount_t;

	// beam position and the windows decoded from it
	typedef struct packed {
		hphase_t hc0;
		hcount_t hc;
		vcount_t vc;
		logic    ck7;
		logic    blank;
		logic    hsync;
		logic    vsync;
		logic    screen_load;
		logic    screen_show;
		logic    screen_update;
		logic    border_update;
		logic    line_end;
	} beam_t;

	typedef struct packed {
		logic g;
		logic r;
		logic b;
		logic i;
	} rgbi_t;

endpackage

/* design/ula_bus_pkg.sv */
package ula_bus_pkg;

	// Z80 address and control, all strobes active low
	typedef struct packed {
		logic [15:0] a;
		logic        n_mreq;
		logic        n_iorq;
		logic        n_rd;
		logic        n_wr;
		logic        n_m1;
		logic        n_rfsh;
	} cpu_bus_t;

	// state of port #7FFD
	typedef struct packed {
		logic [2:0] rambank;
		logic       vbank;
		logic       rombank;
		logic       lock;
	} paging_t;

	// write data as port #FE sees it
	typedef struct packed {
		logic [2:0] unused;
		logic       beeper;
		logic       mic;
		logic [2:0] border;
	} fe_wr_t;

	// write data as port #7FFD sees it
	typedef struct packed {
		logic [1:0] unused;
		logic       lock;
		logic       rombank;
		logic       vbank;
		logic [2:0] rambank;
	} p7ffd_wr_t;

	typedef union packed {
		fe_wr_t    fe;
		p7ffd_wr_t p7ffd;
	} io_wr_data_u;

	typedef struct packed {
		logic       n_romcs;
		logic       n_vrd;
		logic       n_vwr;
		logic [2:0] ra;
	} mem_ctl_t;

endpackage

/* design/video_timing.sv */
`timescale 1ns/1ps

module video_timing import ula_video_pkg::*; #(
	parameter int SCREEN_DELAY = 8
) (
	input  logic  clk14,
	input  logic  rst_n,
	input  logic  timing_sel,
	output beam_t beam,
	output logic  n_int
);

	frame_fmt_t fmt;
	hphase_t hc0;
	vcount_t vc;
	hcount_t hc;
	logic [9:0] hc_w;
	logic [9:0] vc_w;
	logic [9:0] blank_start, hsync_start, hsync_end, blank_end;
	logic [9:0] vsync_start, vsync_end;
	logic line_end, frame_end, in_area, vsync_on, screen_show;

	// timing_sel high picks the 128K frame
	assign fmt = timing_sel ? FMT_128 : FMT_PENT;

	assign hc = hc0[9:1];
	assign hc_w = {1'b0, hc};
	assign vc_w = {1'b0, vc};
	assign line_end = hc0 == (fmt.htotal << 1) - 10'd1;
	assign frame_end = vc_w == fmt.vtotal - 10'd1;

	// border after the screen is widened by the fetch delay
	assign blank_start = 10'(H_AREA + SCREEN_DELAY) + fmt.rborder;
	assign hsync_start = blank_start + fmt.blank1;
	assign hsync_end = hsync_start + fmt.hsync_len;
	assign blank_end = hsync_end + fmt.blank2;
	assign vsync_start = 10'(V_AREA) + fmt.bborder;
	assign vsync_end = vsync_start + fmt.vsync_len;

	assign in_area = vc < 9'(V_AREA);
	assign vsync_on = vc_w >= vsync_start && vc_w < vsync_end;
	assign screen_show = in_area && hc >= 9'(SCREEN_DELAY - 1) &&
		hc_w < 10'(H_AREA + SCREEN_DELAY - 1);

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			hc0 <= '0;
			vc <= '0;
		end else if (line_end) begin
			hc0 <= '0;
			vc <= frame_end ? '0 : vc + 9'd1;
		end else begin
			hc0 <= hc0 + 10'd1;
		end
	end

	always_comb begin
		beam.hc0 = hc0;
		beam.hc = hc;
		beam.vc = vc;
		beam.ck7 = hc0[0];
		beam.hsync = hc_w >= hsync_start && hc_w < hsync_end;
		beam.vsync = vsync_on;
		beam.blank = vsync_on || (hc_w >= blank_start && hc_w < blank_end);
		// the last phase of a line already fetches for the next one
		beam.screen_load = in_area && (hc_w < 10'(H_AREA) || line_end);
		beam.screen_show = screen_show;
		beam.screen_update = in_area && hc_w <= 10'(H_AREA) && hc0[3:0] == 4'b1110;
		// pentagon border follows the port every clock, 128K once per cell
		beam.border_update = !screen_show && (!timing_sel || hc0[3:0] == 4'b1110);
		beam.line_end = line_end;
	end

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n)
			n_int <= 1'b1;
		else
			n_int <= !(vc_w == fmt.int_line && hc_w >= fmt.int_start &&
				hc_w < fmt.int_end);
	end

endmodule

/* design/screen_fetch.sv */
`timescale 1ns/1ps

module screen_fetch import ula_video_pkg::*, ula_bus_pkg::*; (
	input  logic        clk14,
	input  logic        rst_n,
	input  beam_t       beam,
	input  cpu_bus_t    bus,
	input  logic [7:0]  mem_data_in,
	output logic        screen_read,
	output logic [14:0] screen_addr,
	output logic [7:0]  attr_next,
	output logic [7:0]  bitmap_next
);

	logic bus_idle;
	logic attr_read, bitmap_read;
	logic [14:0] bitmap_addr, attr_addr;

	// no IO or M1, and memory either unused or only refreshing
	assign bus_idle = bus.n_iorq && bus.n_m1 && (bus.n_mreq || !bus.n_rfsh);

	// attribute on the low ck7 phase, bitmap on the high one
	assign attr_read = screen_read && !beam.ck7;
	assign bitmap_read = screen_read && beam.ck7;

	// bitmap rows are interleaved in thirds of 64 lines
	assign bitmap_addr = {2'b10, beam.vc[7:6], beam.vc[2:0], beam.vc[5:3], beam.hc[7:3]};
	assign attr_addr = {5'b10110, beam.vc[7:3], beam.hc[7:3]};
	assign screen_addr = beam.ck7 ? bitmap_addr : attr_addr;

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			screen_read <= 1'b0;
			attr_next <= 8'hff;
		end else begin
			screen_read <= beam.screen_load && bus_idle;
			if (attr_read)
				attr_next <= mem_data_in;
			else if (!beam.screen_load)
				// floating bus value seen through port #FF
				attr_next <= 8'hff;
		end
	end

	always_ff @(posedge clk14) begin
		if (bitmap_read)
			bitmap_next <= mem_data_in;
	end

endmodule

/* design/pixel_out.sv */
`timescale 1ns/1ps

module pixel_out import ula_video_pkg::*; #(
	parameter int FLASH_BITS = 5
) (
	input  logic       clk14,
	input  logic       rst_n,
	input  beam_t      beam,
	input  logic       n_int,
	input  logic [7:0] attr_next,
	input  logic [7:0] bitmap_next,
	input  logic [2:0] border,
	output rgbi_t      rgbi,
	output logic       hsync,
	output logic       vsync,
	output logic       csync
);

	logic [7:0] bitmap, attr;
	logic [FLASH_BITS-1:0] flash_cnt;
	logic n_int_d;
	logic flash, pixel;
	logic [2:0] colour;

	assign flash = flash_cnt[FLASH_BITS-1];
	// flashing cells swap ink and paper
	assign pixel = bitmap[7] ^ (attr[7] & flash);
	assign colour = pixel ? attr[2:0] : attr[5:3];

	// frame count, stepped on the falling edge of the interrupt
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			n_int_d <= 1'b1;
			flash_cnt <= '0;
		end else begin
			n_int_d <= n_int;
			if (n_int_d && !n_int)
				flash_cnt <= flash_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk14) begin
		// border drawn as paper of a dark cell
		if (beam.border_update)
			attr <= {2'b00, border, 3'b000};
		else if (beam.screen_update)
			attr <= attr_next;
		if (beam.screen_update)
			bitmap <= bitmap_next;
		else if (beam.ck7)
			bitmap <= {bitmap[6:0], 1'b0};
	end

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			rgbi <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			csync <= 1'b1;
		end else if (beam.ck7) begin
			if (beam.blank) begin
				rgbi <= '0;
			end else begin
				rgbi.g <= colour[2];
				rgbi.r <= colour[1];
				rgbi.b <= colour[0];
				// no bright black
				rgbi.i <= (|colour) & attr[6];
			end
			hsync <= beam.hsync;
			vsync <= beam.vsync;
			csync <= ~(beam.hsync ^ beam.vsync);
		end
	end

endmodule

/* design/io_ports.sv */
`timescale 1ns/1ps

module io_ports import ula_bus_pkg::*; (
	input  logic        clk14,
	input  logic        rst_n,
	input  cpu_bus_t    bus,
	input  io_wr_data_u cpu_data_in,
	input  logic [4:0]  kd,
	input  logic        tape_in,
	input  logic [7:0]  attr_next,
	input  logic        screen_read,
	output paging_t     paging,
	output logic [2:0]  border,
	output logic        beeper,
	output logic        tape_out,
	output logic [7:0]  cpu_data_out,
	output logic        cpu_data_oe
);

	logic io_wr, io_rd;
	logic fe_cs, p7ffd_cs;
	logic fe_rd, ff_rd;
	logic mic;

	assign io_wr = !bus.n_iorq && !bus.n_wr;
	assign io_rd = !bus.n_iorq && !bus.n_rd;

	// partial decode as on the original machine
	assign fe_cs = !bus.a[0];
	assign p7ffd_cs = !bus.a[1] && !bus.a[15] && (bus.a[14] || bus.a[13]);

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			border <= '0;
			beeper <= 1'b0;
			mic <= 1'b0;
			paging <= '0;
		end else if (io_wr) begin
			if (fe_cs) begin
				border <= cpu_data_in.fe.border;
				beeper <= cpu_data_in.fe.beeper;
				mic <= cpu_data_in.fe.mic;
			end
			// paging frozen once the lock bit is set
			if (p7ffd_cs && !paging.lock) begin
				paging.rambank <= cpu_data_in.p7ffd.rambank;
				paging.vbank <= cpu_data_in.p7ffd.vbank;
				paging.rombank <= cpu_data_in.p7ffd.rombank;
				paging.lock <= cpu_data_in.p7ffd.lock;
			end
		end
	end

	// read selects, released one clock after n_rd rises
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			fe_rd <= 1'b0;
			ff_rd <= 1'b0;
		end else begin
			fe_rd <= io_rd && fe_cs;
			ff_rd <= io_rd && !fe_cs && !screen_read;
		end
	end

	assign tape_out = mic ^ tape_in;
	assign cpu_data_oe = fe_rd || ff_rd;
	// anything but #FE returns the floating attribute
	assign cpu_data_out = fe_rd ? {1'b1, tape_in, 1'b1, kd} : attr_next;

endmodule

/* design/mem_map.sv */
`timescale 1ns/1ps

module mem_map import ula_bus_pkg::*; (
	input  logic        clk14,
	input  logic        rst_n,
	input  cpu_bus_t    bus,
	input  paging_t     paging,
	input  logic        screen_read,
	input  logic [14:0] screen_addr,
	output mem_ctl_t    mem,
	output logic [18:0] mem_addr
);

	logic rom_hit, ram_hit;
	logic n_romcs_q, n_ramcs_q, n_vwr_q;
	logic [5:0] ram_page;

	// refresh cycles must not touch either chip
	assign rom_hit = !bus.n_mreq && bus.n_rfsh && !bus.a[15] && !bus.a[14];
	assign ram_hit = !bus.n_mreq && bus.n_rfsh && (bus.a[15] || bus.a[14]);

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			n_romcs_q <= 1'b1;
			n_ramcs_q <= 1'b1;
			n_vwr_q <= 1'b1;
		end else begin
			n_romcs_q <= !rom_hit;
			n_ramcs_q <= !ram_hit;
			n_vwr_q <= !ram_hit || bus.n_wr || screen_read;
		end
	end

	// 4000 -> bank 5, 8000 -> bank 2, C000 -> paged bank
	always_ff @(posedge clk14) begin
		if (bus.a[15] && bus.a[14])
			ram_page <= {2'b11, paging.rambank, bus.a[13]};
		else
			ram_page <= {2'b11, bus.a[14], bus.a[15], bus.a[14], bus.a[13]};
	end

	always_comb begin
		mem.n_romcs = n_romcs_q | bus.n_mreq;
		mem.n_vrd = (n_ramcs_q | bus.n_rd) & ~screen_read;
		mem.n_vwr = n_vwr_q | bus.n_wr | screen_read;
		mem.ra = {2'b00, paging.rombank};
	end

	// video fetch takes the address bus from the CPU
	assign mem_addr = screen_read ? {3'b111, paging.vbank, screen_addr} :
		{ram_page, bus.a[12:0]};

endmodule

/* design/zx_ula.sv */
`timescale 1ns/1ps

module zx_ula import ula_video_pkg::*, ula_bus_pkg::*; #(
	parameter int SCREEN_DELAY = 8,
	parameter int FLASH_BITS = 5
) (
	input  logic        clk14,
	input  logic        rst_n,
	input  logic        timing_sel,
	input  cpu_bus_t    bus,
	input  io_wr_data_u cpu_data_in,
	output logic [7:0]  cpu_data_out,
	output logic        cpu_data_oe,
	input  logic [7:0]  mem_data_in,
	output logic [18:0] mem_addr,
	output mem_ctl_t    mem,
	input  logic [4:0]  kd,
	input  logic        tape_in,
	output logic        tape_out,
	output logic        beeper,
	output logic        n_int,
	output rgbi_t       rgbi,
	output logic        hsync,
	output logic        vsync,
	output logic        csync
);

	beam_t beam;
	paging_t paging;
	logic screen_read;
	logic [14:0] screen_addr;
	logic [7:0] attr_next, bitmap_next;
	logic [2:0] border;

	video_timing #(
		.SCREEN_DELAY(SCREEN_DELAY)
	) video_timing_i (
		.clk14(clk14), .rst_n(rst_n), .timing_sel(timing_sel),
		.beam(beam), .n_int(n_int)
	);

	screen_fetch screen_fetch_i (
		.clk14(clk14), .rst_n(rst_n), .beam(beam), .bus(bus),
		.mem_data_in(mem_data_in), .screen_read(screen_read),
		.screen_addr(screen_addr), .attr_next(attr_next), .bitmap_next(bitmap_next)
	);

	pixel_out #(
		.FLASH_BITS(FLASH_BITS)
	) pixel_out_i (
		.clk14(clk14), .rst_n(rst_n), .beam(beam), .n_int(n_int),
		.attr_next(attr_next), .bitmap_next(bitmap_next), .border(border),
		.rgbi(rgbi), .hsync(hsync), .vsync(vsync), .csync(csync)
	);

	io_ports io_ports_i (
		.clk14(clk14), .rst_n(rst_n), .bus(bus), .cpu_data_in(cpu_data_in),
		.kd(kd), .tape_in(tape_in), .attr_next(attr_next), .screen_read(screen_read),
		.paging(paging), .border(border), .beeper(beeper), .tape_out(tape_out),
		.cpu_data_out(cpu_data_out), .cpu_data_oe(cpu_data_oe)
	);

	mem_map mem_map_i (
		.clk14(clk14), .rst_n(rst_n), .bus(bus), .paging(paging),
		.screen_read(screen_read), .screen_addr(screen_addr),
		.mem(mem), .mem_addr(mem_addr)
	);

endmodule

/* dv/tb_zx_ula.sv */
`timescale 1ns/1ps

module tb_zx_ula import ula_video_pkg::*, ula_bus_pkg::*;;

	// three frames per mode and half as much again, 40 ns per clock
	localparam longint WATCHDOG_NS = 64'd3 * (64'd912 * 311 + 64'd896 * 320) * 3 / 2 * 40;

	logic clk14 = 1'b0;
	logic rst_n;
	logic timing_sel;
	cpu_bus_t bus;
	io_wr_data_u cpu_data_in;
	logic [7:0] cpu_data_out;
	logic cpu_data_oe;
	logic [7:0] mem_data_in;
	logic [18:0] mem_addr;
	mem_ctl_t mem;
	logic [4:0] kd;
	logic tape_in, tape_out, beeper, n_int;
	rgbi_t rgbi;
	logic hsync, vsync, csync;

	// frame model
	int htot, vtot, int_line, int_start, int_end;
	int m_hc0, m_vc;
	int cyc, last_fe, hs_last, vs_last, low_len, fetches;
	logic active, hs_prev, vs_prev, hs_seen, vs_seen, int_prev;
	// shadow port registers
	logic [2:0] sh_border, sh_rambank;
	logic sh_beeper, sh_mic, sh_vbank, sh_rombank, sh_lock;
	logic [15:0] lfsr = 16'd5;

	zx_ula zx_ula_i (
		.clk14(clk14), .rst_n(rst_n), .timing_sel(timing_sel), .bus(bus),
		.cpu_data_in(cpu_data_in), .cpu_data_out(cpu_data_out), .cpu_data_oe(cpu_data_oe),
		.mem_data_in(mem_data_in), .mem_addr(mem_addr), .mem(mem), .kd(kd),
		.tape_in(tape_in), .tape_out(tape_out), .beeper(beeper), .n_int(n_int),
		.rgbi(rgbi), .hsync(hsync), .vsync(vsync), .csync(csync)
	);

	always #20 clk14 = ~clk14;

	// galois LFSR, one step per bit taken
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		r = '0;
		for (int k = 0; k < n; k++) begin
			r = {r[14:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 16'hb400 : lfsr >> 1;
		end
		return r;
	endfunction

	task automatic stop_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_rgbi(input rgbi_t got, input rgbi_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: rgbi got %b expected %b", $time, got, exp);
			stop_run();
		end
	endtask

	task automatic check_mem(input mem_ctl_t got_c, input logic [18:0] got_a,
			input mem_ctl_t exp_c, input logic [18:0] exp_a);
		if (got_c !== exp_c || got_a !== exp_a) begin
			$display("mismatch at %0t: mem/mem_addr got %b/%h expected %b/%h",
				$time, got_c, got_a, exp_c, exp_a);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			stop_run();
		end
	endtask

	// beam model
	always @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			m_hc0 <= 0;
			m_vc <= 0;
		end else if (m_hc0 == 2 * htot - 1) begin
			m_hc0 <= 0;
			m_vc <= (m_vc == vtot - 1) ? 0 : m_vc + 1;
		end else begin
			m_hc0 <= m_hc0 + 1;
		end
	end

	always @(negedge clk14) begin
		logic [14:0] exp_sa;
		logic [8:0] vc9;
		logic [8:0] hc9;
		if (active) begin
			cyc++;
			if (hsync && !hs_prev) begin
				if (hs_seen)
					check_count("hsync period", cyc - hs_last, 2 * htot);
				hs_seen = 1'b1;
				hs_last = cyc;
			end
			hs_prev = hsync;
			if (vsync && !vs_prev) begin
				if (vs_seen)
					check_count("vsync period", cyc - vs_last, 2 * htot * vtot);
				vs_seen = 1'b1;
				vs_last = cyc;
			end
			vs_prev = vsync;
			// composite sync is low while exactly one of the syncs is active
			check_bit("csync", csync, !(hsync ^ vsync));
			if (!n_int && int_prev) begin
				check_count("n_int fall column", m_hc0, 2 * int_start + 1);
				check_count("n_int fall line", m_vc, int_line);
				low_len = 0;
			end
			if (!n_int)
				low_len++;
			if (n_int && !int_prev)
				check_count("n_int low length", low_len, 2 * (int_end - int_start));
			int_prev = n_int;
			// screen fetch slot, with no CPU memory request
			if (!mem.n_vrd && bus.n_mreq && m_vc < 192) begin
				vc9 = 9'(m_vc);
				hc9 = 9'(m_hc0 >> 1);
				if (m_hc0 % 2 == 1)
					exp_sa = {2'b10, vc9[7:6], vc9[2:0], vc9[5:3], hc9[7:3]};
				else
					exp_sa = {5'b10110, vc9[7:3], hc9[7:3]};
				check_mem(mem, mem_addr, mem_ctl_t'({1'b1, 1'b0, 1'b1, 2'b00, sh_rombank}),
					{3'b111, sh_vbank, exp_sa});
				fetches++;
				mem_data_in = 8'(rand_bits(8));
			end
			// lower border well away from blanking
			if (m_vc >= 200 && m_vc < 240 && m_hc0 >= 64 && m_hc0 < 400 && cyc - last_fe > 40)
				check_rgbi(rgbi, rgbi_t'({sh_border, 1'b0}));
		end
	end

	task automatic write_fe();
		logic [7:0] d;
		d = 8'(rand_bits(8));
		tape_in = 1'(rand_bits(1));
		bus.a = 16'h00fe;
		cpu_data_in = d;
		bus.n_iorq = 1'b0;
		bus.n_wr = 1'b0;
		@(negedge clk14);
		sh_border = d[2:0];
		sh_mic = d[3];
		sh_beeper = d[4];
		last_fe = cyc;
		bus.n_iorq = 1'b1;
		bus.n_wr = 1'b1;
		check_bit("beeper", beeper, sh_beeper);
		check_bit("tape_out", tape_out, sh_mic ^ tape_in);
		@(negedge clk14);
	endtask

	task automatic read_port(input logic [15:0] addr, input logic [7:0] exp);
		bus.a = addr;
		bus.n_iorq = 1'b0;
		bus.n_rd = 1'b0;
		@(negedge clk14);
		check_bit("cpu_data_oe", cpu_data_oe, 1'b1);
		check_byte("cpu_data_out", cpu_data_out, exp);
		bus.n_iorq = 1'b1;
		bus.n_rd = 1'b1;
		@(negedge clk14);
		check_bit("cpu_data_oe", cpu_data_oe, 1'b0);
	endtask

	task automatic write_7ffd();
		logic [7:0] d;
		d = 8'(rand_bits(8));
		bus.a = 16'h7ffd;
		cpu_data_in = d;
		bus.n_iorq = 1'b0;
		bus.n_wr = 1'b0;
		@(negedge clk14);
		if (!sh_lock) begin
			sh_rambank = d[2:0];
			sh_vbank = d[3];
			sh_rombank = d[4];
			sh_lock = d[5];
		end
		bus.n_iorq = 1'b1;
		bus.n_wr = 1'b1;
		@(negedge clk14);
	endtask

	task automatic read_mem();
		logic [1:0] page;
		logic [13:0] off;
		logic [2:0] bank;
		page = 2'(rand_bits(2));
		off = 14'(rand_bits(14));
		bank = page == 2'd1 ? 3'd5 : page == 2'd2 ? 3'd2 : sh_rambank;
		bus.a = {page, off};
		bus.n_mreq = 1'b0;
		bus.n_rd = 1'b0;
		@(negedge clk14);
		if (page == 2'd0) begin
			check_bit("n_romcs", mem.n_romcs, 1'b0);
			check_bit("n_vrd", mem.n_vrd, 1'b1);
		end else begin
			check_mem(mem, mem_addr, mem_ctl_t'({1'b1, 1'b0, 1'b1, 2'b00, sh_rombank}),
				{2'b11, bank, off});
		end
		bus.n_mreq = 1'b1;
		bus.n_rd = 1'b1;
		@(negedge clk14);
	endtask

	task automatic run_mode(input logic sel, input int ht, input int vt,
			input int il, input int is, input int ie);
		logic [2:0] op;
		logic [7:0] hi;
		active = 1'b0;
		rst_n = 1'b0;
		timing_sel = sel;
		htot = ht;
		vtot = vt;
		int_line = il;
		int_start = is;
		int_end = ie;
		repeat (4) @(negedge clk14);
		{cyc, last_fe, hs_last, vs_last, low_len, fetches} = '0;
		{hs_prev, vs_prev, hs_seen, vs_seen} = '0;
		int_prev = 1'b1;
		{sh_border, sh_beeper, sh_mic} = '0;
		{sh_rambank, sh_vbank, sh_rombank, sh_lock} = '0;
		rst_n = 1'b1;
		active = 1'b1;
		while (cyc < 3 * 2 * htot * vtot) begin
			op = 3'(rand_bits(3));
			case (op)
				3'd0, 3'd1: write_fe();
				3'd2: begin
					kd = 5'(rand_bits(5));
					tape_in = 1'(rand_bits(1));
					hi = 8'(rand_bits(8));
					read_port({hi, 8'hfe}, {1'b1, tape_in, 1'b1, kd});
				end
				3'd3: write_7ffd();
				3'd4, 3'd5: read_mem();
				3'd6: begin
					if (m_vc >= 200 && m_vc < 236)
						read_port(16'h40ff, 8'hff);
					else
						@(negedge clk14);
				end
				default: repeat (4'(rand_bits(4)) + 1) @(negedge clk14);
			endcase
		end
		if (fetches == 0) begin
			$display("no screen fetch was seen in this mode");
			stop_run();
		end
		active = 1'b0;
	endtask

	initial begin
		#WATCHDOG_NS;
		$display("timeout: the run did not finish in time");
		$display("Simulation finished: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		active = 1'b0;
		rst_n = 1'b0;
		timing_sel = 1'b1;
		bus = '{a: 16'h0000, default: 1'b1};
		cpu_data_in = '0;
		mem_data_in = '0;
		kd = '1;
		tape_in = 1'b0;
		// 128K frame first, then Pentagon
		run_mode(1'b1, 456, 311, 248, 0, 64);
		run_mode(1'b0, 448, 320, 239, 318, 384);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* zx_ula.f */
design/ula_video_pkg.sv
design/ula_bus_pkg.sv
design/video_timing.sv
design/screen_fetch.sv
design/pixel_out.sv
design/io_ports.sv
design/mem_map.sv
design/zx_ula.sv
dv/tb_zx_ula.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_zx_ula -f zx_ula.f -o tb_zx_ula \
	> sim.log 2>&1 && ./obj_dir/tb_zx_ula >> sim.log 2>&1
grep -q "Simulation finished: FAIL" sim.log && { echo "simulation failed"; exit 1; } || \
	{ grep -q "Simulation finished: PASS" sim.log && echo "simulation passed" || \
	{ echo "build or run failed, see sim.log"; exit 1; }; }
